// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --assert --timing -f src.f --top-module tb_fp_rsqrt \
		--Mdir obj_dir -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	@if grep -q "SOME TESTS FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q "ALL TESTS PASSED" sim.log; then echo "simulation incomplete"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir sim.log

// ==== hw/fixed_mult.sv ====
`default_nettype none
`timescale 1ns/1ps

module fixed_mult #(
    parameter int WIDTH = 28
) (
    input  logic               clk,
    input  logic               rst,
    input  logic [WIDTH-1:0]   a,
    input  logic [WIDTH-1:0]   b,
    output logic [2*WIDTH-1:0] p
);

    logic [WIDTH-1:0] a_q;
    logic [WIDTH-1:0] b_q;

    // operand register, then product register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            a_q <= '0;
            b_q <= '0;
            p   <= '0;
        end else begin
            a_q <= a;
            b_q <= b;
            p   <= a_q * b_q;
        end
    end

endmodule

`default_nettype wire

// ==== hw/fp_pkg.sv ====
`default_nettype none

package fp_pkg;

    // binary32 word, sign in the top bit
    typedef struct packed {
        logic        sign;
        logic [7:0]  exponent;
        logic [22:0] mantissa;
    } fp32_t;

    // exception flags raised with each result
    typedef struct packed {
        logic invalid;
        logic div_by_zero;
        logic underflow;
        logic inexact;
    } fp_flags_t;

    localparam int FP_EXP_BIAS = 127;

    // default quiet NaN returned for operands with the sign set
    localparam fp32_t FP_QNAN_NEG = 32'hFFC0_0000;
    localparam fp32_t FP_POS_INF = 32'h7F80_0000;

    // mantissa bit that separates quiet from signalling NaN
    localparam int FP_QUIET_BIT = 22;

endpackage

`default_nettype wire

// ==== hw/fp_rsqrt.sv ====
`default_nettype none
`timescale 1ns/1ps

module fp_rsqrt
    import fp_pkg::*;
    import rsqrt_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      valid_in,
    input  fp32_t     operand,
    output fp32_t     result,
    output fp_flags_t flags,
    output logic      valid_out
);

    rsqrt_meta_t cls_meta;
    logic [24:0] cls_mant;
    fix_prod_t   nwt_mant;
    rsqrt_meta_t nwt_meta;

    rsqrt_classify u_classify (
        .clk      (clk),
        .rst      (rst),
        .valid_in (valid_in),
        .operand  (operand),
        .meta     (cls_meta),
        .mant_in  (cls_mant)
    );

    rsqrt_newton u_newton (
        .clk      (clk),
        .rst      (rst),
        .mant_in  (cls_mant),
        .meta_in  (cls_meta),
        .mant_out (nwt_mant),
        .meta_out (nwt_meta)
    );

    rsqrt_round u_round (
        .clk       (clk),
        .rst       (rst),
        .mant_in   (nwt_mant),
        .meta_in   (nwt_meta),
        .result    (result),
        .flags     (flags),
        .valid_out (valid_out)
    );

endmodule

`default_nettype wire

// ==== hw/rsqrt_classify.sv ====
`default_nettype none
`timescale 1ns/1ps

module rsqrt_classify
    import fp_pkg::*;
    import rsqrt_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        valid_in,
    input  fp32_t       operand,
    output rsqrt_meta_t meta,
    output logic [24:0] mant_in
);

    logic               exp_zero;
    logic               exp_ones;
    logic               man_zero;
    logic               is_zero;
    logic               is_inf;
    logic               is_qnan;
    logic               is_snan;
    logic               is_denorm;
    logic               exp_even;
    logic [8:0]         exp_num;
    rsqrt_meta_t        meta_d;
    logic [24:0]        mant_d;

    assign exp_zero = (operand.exponent == '0);
    assign exp_ones = (operand.exponent == '1);
    assign man_zero = (operand.mantissa == '0);

    assign is_zero   = exp_zero & man_zero;
    assign is_denorm = exp_zero & ~man_zero;
    assign is_inf    = exp_ones & man_zero;
    assign is_qnan   = exp_ones & ~man_zero & operand.mantissa[FP_QUIET_BIT];
    assign is_snan   = exp_ones & ~man_zero & ~operand.mantissa[FP_QUIET_BIT];

    // even biased exponent means an odd true exponent, so fold a factor of two into the mantissa
    assign exp_even = ~operand.exponent[0];
    assign mant_d   = exp_even ? {1'b1, operand.mantissa, 1'b0} : {2'b01, operand.mantissa};

    // half of this is the exponent for a result in [1, 2)
    assign exp_num = 9'(3 * FP_EXP_BIAS) + 9'(exp_even) - 9'(operand.exponent);

    always_comb begin
        meta_d         = '0;
        meta_d.valid   = valid_in;
        meta_d.sign    = operand.sign;
        meta_d.res_exp = exp_num[8:1];
        if (is_qnan) begin
            meta_d.special        = 1'b1;
            meta_d.special_result = operand;
        end else if (is_snan) begin
            meta_d.special        = 1'b1;
            meta_d.special_result = operand;
            meta_d.special_result.mantissa[FP_QUIET_BIT] = 1'b1;
            meta_d.invalid        = 1'b1;
        end else if (operand.sign) begin
            meta_d.special        = 1'b1;
            meta_d.special_result = FP_QNAN_NEG;
        end else if (is_inf) begin
            // +0 is already in special_result
            meta_d.special = 1'b1;
        end else if (is_zero | is_denorm) begin
            meta_d.special        = 1'b1;
            meta_d.special_result = FP_POS_INF;
            meta_d.div_by_zero    = 1'b1;
            meta_d.flushed        = is_denorm;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            meta    <= '0;
            mant_in <= '0;
        end else begin
            meta    <= meta_d;
            mant_in <= mant_d;
        end
    end

endmodule

`default_nettype wire

// ==== hw/rsqrt_newton.sv ====
`default_nettype none
`timescale 1ns/1ps

module rsqrt_newton
    import rsqrt_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic [24:0] mant_in,
    input  rsqrt_meta_t meta_in,
    output fix_prod_t   mant_out,
    output rsqrt_meta_t meta_out
);

    fix_t        seed_rom [2**SEED_INDEX_W];

    // a_dly[k], x_dly[k] hold stage k+1; x1_dly[k] holds stage 9+k
    fix_t        a_dly  [4*MULT_LATENCY + 2];
    fix_t        x_dly  [2*MULT_LATENCY + 2];
    fix_t        x1_dly [2*MULT_LATENCY + 1];
    rsqrt_meta_t meta_dly [NEWTON_LATENCY];

    fix_prod_t   sq1_p;
    fix_prod_t   ax1_p;
    fix_prod_t   nx1_p;
    fix_prod_t   sq2_p;
    fix_prod_t   ax2_p;
    fix_t        z1_q;
    fix_t        z2_q;
    fix_t        x1;
    fix_t        x0_half;
    fix_t        x1_half;

    function automatic fix_t to_fix(input fix_prod_t prod);
        return prod[FIX_FRAC_BITS +: $bits(fix_t)];
    endfunction

    initial begin
        $readmemh(SEED_FILE, seed_rom);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < $size(a_dly); i++) begin
                a_dly[i] <= '0;
            end
            for (int i = 0; i < $size(x_dly); i++) begin
                x_dly[i] <= '0;
            end
            for (int i = 0; i < $size(x1_dly); i++) begin
                x1_dly[i] <= '0;
            end
            z1_q <= '0;
            z2_q <= '0;
        end else begin
            // seed lookup on the top mantissa bits
            x_dly[0] <= seed_rom[mant_in[24 -: SEED_INDEX_W]];
            a_dly[0] <= fix_t'({mant_in, 3'b000});
            for (int i = 1; i < $size(a_dly); i++) begin
                a_dly[i] <= a_dly[i-1];
            end
            for (int i = 1; i < $size(x_dly); i++) begin
                x_dly[i] <= x_dly[i-1];
            end
            x1_dly[0] <= x1;
            for (int i = 1; i < $size(x1_dly); i++) begin
                x1_dly[i] <= x1_dly[i-1];
            end
            z1_q <= FIX_THREE - to_fix(ax1_p);
            z2_q <= FIX_THREE - to_fix(ax2_p);
        end
    end

    // first iteration
    fixed_mult #(.WIDTH(28)) u_sq1 (
        .clk(clk), .rst(rst), .a(x_dly[0]), .b(x_dly[0]), .p(sq1_p)
    );
    fixed_mult #(.WIDTH(28)) u_ax1 (
        .clk(clk), .rst(rst), .a(a_dly[MULT_LATENCY]), .b(to_fix(sq1_p)), .p(ax1_p)
    );
    assign x0_half = x_dly[2*MULT_LATENCY + 1] >> 1;
    fixed_mult #(.WIDTH(28)) u_nx1 (
        .clk(clk), .rst(rst), .a(x0_half), .b(z1_q), .p(nx1_p)
    );
    assign x1 = to_fix(nx1_p);

    // second iteration
    fixed_mult #(.WIDTH(28)) u_sq2 (
        .clk(clk), .rst(rst), .a(x1), .b(x1), .p(sq2_p)
    );
    fixed_mult #(.WIDTH(28)) u_ax2 (
        .clk(clk), .rst(rst), .a(a_dly[4*MULT_LATENCY + 1]), .b(to_fix(sq2_p)), .p(ax2_p)
    );
    assign x1_half = x1_dly[2*MULT_LATENCY] >> 1;
    fixed_mult #(.WIDTH(28)) u_nx2 (
        .clk(clk), .rst(rst), .a(x1_half), .b(z2_q), .p(mant_out)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NEWTON_LATENCY; i++) begin
                meta_dly[i] <= '0;
            end
        end else begin
            meta_dly[0] <= meta_in;
            for (int i = 1; i < NEWTON_LATENCY; i++) begin
                meta_dly[i] <= meta_dly[i-1];
            end
        end
    end

    assign meta_out = meta_dly[NEWTON_LATENCY-1];

endmodule

`default_nettype wire

// ==== hw/rsqrt_pkg.sv ====
`default_nettype none

package rsqrt_pkg;

    import fp_pkg::*;

    // Q2.26 estimate and operand, Q4.52 raw product
    typedef logic [27:0] fix_t;
    typedef logic [55:0] fix_prod_t;

    localparam int FIX_FRAC_BITS = 26;
    localparam fix_t FIX_THREE = 28'hC00_0000;

    localparam int SEED_INDEX_W = 6;
    localparam string SEED_FILE = "hw/rsqrt_seed_lut.mem";

    localparam int MULT_LATENCY = 2;
    localparam int NEWTON_LATENCY = 15;
    localparam int RSQRT_LATENCY = 17;

    // sideband that travels beside the mantissa through the pipeline
    typedef struct packed {
        logic       valid;
        logic       sign;
        logic       special;
        fp32_t      special_result;
        logic       invalid;
        logic       flushed;
        logic       div_by_zero;
        logic [7:0] res_exp;
    } rsqrt_meta_t;

endpackage

`default_nettype wire

// ==== hw/rsqrt_round.sv ====
`default_nettype none
`timescale 1ns/1ps

module rsqrt_round
    import fp_pkg::*;
    import rsqrt_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  fix_prod_t   mant_in,
    input  rsqrt_meta_t meta_in,
    output fp32_t       result,
    output fp_flags_t   flags,
    output logic        valid_out
);

    logic [22:0] mant_trunc;
    logic        guard;
    logic        round_bit;
    logic        sticky;
    logic        round_up;
    logic [23:0] mant_rnd;
    logic [7:0]  exp_norm;
    logic [7:0]  exp_rnd;
    fp32_t       norm_result;

    always_comb begin
        // estimate lies in (0.5, 1], only exactly 1.0 reaches bit 52
        if (mant_in[52]) begin
            mant_trunc = mant_in[51:29];
            guard      = mant_in[28];
            round_bit  = mant_in[27];
            sticky     = |mant_in[26:0];
            exp_norm   = meta_in.res_exp;
        end else begin
            mant_trunc = mant_in[50:28];
            guard      = mant_in[27];
            round_bit  = mant_in[26];
            sticky     = |mant_in[25:0];
            exp_norm   = meta_in.res_exp - 8'd1;
        end
        // nearest even, ties go to an even lsb
        round_up    = guard & (round_bit | sticky | mant_trunc[0]);
        mant_rnd    = {1'b0, mant_trunc} + 24'(round_up);
        exp_rnd     = mant_rnd[23] ? exp_norm + 8'd1 : exp_norm;
        norm_result = {meta_in.sign, exp_rnd, mant_rnd[22:0]};
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            result    <= '0;
            flags     <= '0;
            valid_out <= 1'b0;
        end else begin
            valid_out         <= meta_in.valid;
            flags.invalid     <= meta_in.invalid;
            flags.div_by_zero <= meta_in.div_by_zero;
            if (meta_in.special) begin
                result          <= meta_in.special_result;
                flags.underflow <= meta_in.flushed;
                flags.inexact   <= 1'b0;
            end else begin
                result          <= norm_result;
                flags.underflow <= 1'b0;
                flags.inexact   <= guard | round_bit | sticky;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/rsqrt_seed_lut.mem ====
4000000
4000000
4000000
4000000
4000000
4000000
4000000
4000000
4000000
4000000
4000000
4000000
4000000
4000000
4000000
4000000
4000000
3D30000
3B80000
3A00000
3890000
3730000
3600000
34D0000
33C0000
32B0000
31C0000
30D0000
2FF0000
2F20000
2E60000
2DA0000
2CE0000
2C40000
2B90000
2AF0000
2A60000
29D0000
2940000
28C0000
2840000
27C0000
2740000
26D0000
2660000
25F0000
2590000
2520000
24C0000
2460000
2400000
23B0000
2350000
2300000
22B0000
2260000
2210000
21C0000
2180000
2130000
20F0000
20A0000
2060000
2020000

// ==== src.f ====
hw/fp_pkg.sv
hw/rsqrt_pkg.sv
hw/rsqrt_classify.sv
hw/fixed_mult.sv
hw/rsqrt_newton.sv
hw/rsqrt_round.sv
hw/fp_rsqrt.sv
tb/rsqrt_asserts.sv
tb/rsqrt_checker.sv
tb/tb_fp_rsqrt.sv

// ==== tb/rsqrt_asserts.sv ====
`default_nettype none
`timescale 1ns/1ps

module rsqrt_asserts
    import fp_pkg::*;
    import rsqrt_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input logic      valid_in,
    input fp32_t     result,
    input fp_flags_t flags,
    input logic      valid_out
);

    logic [RSQRT_LATENCY-1:0] valid_hist;

    // valid_in history, cleared with the pipeline
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_hist <= '0;
        end else begin
            valid_hist <= {valid_hist[RSQRT_LATENCY-2:0], valid_in};
        end
    end

    // fixed pipeline depth, no stalls
    valid_latency: assert property (@(posedge clk) disable iff (rst)
        valid_out == valid_hist[RSQRT_LATENCY-1])
        else $error("valid_out does not follow valid_in by the pipeline latency");

    // only a denormal operand underflows, and it also divides by zero
    underflow_dbz: assert property (@(posedge clk) disable iff (rst)
        flags.underflow |-> flags.div_by_zero)
        else $error("underflow raised without div_by_zero");

    no_snan_out: assert property (@(posedge clk) disable iff (rst)
        valid_out |-> !(result.exponent == 8'hFF && result.mantissa != '0
                        && !result.mantissa[FP_QUIET_BIT]))
        else $error("signalling NaN on result");

endmodule

bind fp_rsqrt rsqrt_asserts u_asserts (
    .clk       (clk),
    .rst       (rst),
    .valid_in  (valid_in),
    .result    (result),
    .flags     (flags),
    .valid_out (valid_out)
);

`default_nettype wire

// ==== tb/rsqrt_checker.sv ====
`default_nettype none
`timescale 1ns/1ps

module rsqrt_checker
    import fp_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  fp32_t     result,
    input  fp_flags_t flags,
    input  logic      valid_out,
    output int        checked,
    output int        failed
);

    logic [31:0] op_q [$];
    logic [31:0] exp_q [$];
    int          tol_q [$];
    logic [3:0]  flag_q [$];

    initial begin
        int          fd;
        int          n;
        int          tol;
        string       line;
        logic [31:0] op;
        logic [31:0] ex;
        logic [3:0]  fl;
        checked = 0;
        failed  = 0;
        fd = $fopen("tb/rsqrt_stim.txt", "r");
        if (fd == 0) begin
            $display("checker could not open the stimulus file");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() == 0 || line[0] == 8'h23) begin
                    continue;
                end
                n = $sscanf(line, "%h %h %d %h", op, ex, tol, fl);
                if (n == 4) begin
                    op_q.push_back(op);
                    exp_q.push_back(ex);
                    tol_q.push_back(tol);
                    flag_q.push_back(fl);
                end
            end
            $fclose(fd);
        end
    end

    task automatic check_one();
        int unsigned diff;
        logic [31:0] ex;
        bit          ok;
        ok = 1'b1;
        if (checked >= exp_q.size()) begin
            $display("result %h arrived with no test left to match it", result);
            failed = failed + 1;
        end else begin
            ex   = exp_q[checked];
            diff = (result > ex) ? result - ex : ex - result;
            if (diff > tol_q[checked]) begin
                $display("ERROR result got %h expected %h", result, ex);
                ok = 1'b0;
            end
            if (flags != flag_q[checked]) begin
                $display("ERROR flags got %h expected %h", flags, flag_q[checked]);
                ok = 1'b0;
            end
            $display("test %0d operand %h: %s", checked, op_q[checked], ok ? "PASS" : "FAIL");
            if (!ok) begin
                failed = failed + 1;
            end
            checked = checked + 1;
        end
    endtask

    // outputs settle right after the rising edge
    always @(negedge clk) begin
        if (!rst && valid_out) begin
            check_one();
        end
    end

endmodule

`default_nettype wire

// ==== tb/rsqrt_stim.txt ====
# operand(hex) expected_result(hex) ulp_tolerance(dec) flags(hex)
# flags bits: invalid, div_by_zero, underflow, inexact
3F800000 3F800000 0 0
40800000 3F000000 0 0
3E800000 40000000 0 0
00800000 5F000000 0 0
40000000 3F3504F3 2 1
40400000 3F13CD3A 2 1
41200000 3EA1E89B 2 1
3F000000 3FB504F3 2 1
41000000 3EB504F3 2 1
7FC00001 7FC00001 0 0
7F800001 7FC00001 0 8
FF812345 FFC12345 0 8
BF800000 FFC00000 0 0
C1200000 FFC00000 0 0
FF800000 FFC00000 0 0
80000000 FFC00000 0 0
7F800000 00000000 0 0
00000000 7F800000 0 4
00000001 7F800000 0 6
007FFFFF 7F800000 0 6
40800000 3F000000 0 0
40000000 3F3504F3 2 1

// ==== tb/tb_fp_rsqrt.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_fp_rsqrt
    import fp_pkg::*;
    import rsqrt_pkg::*;
;

    logic        clk;
    logic        rst;
    logic        valid_in;
    fp32_t       operand;
    fp32_t       result;
    fp_flags_t   flags;
    logic        valid_out;
    int          checked;
    int          failed;
    int          cycles = 0;
    int          limit;
    logic [31:0] rng_state;
    logic [31:0] ops [$];

    fp_rsqrt dut (
        .clk       (clk),
        .rst       (rst),
        .valid_in  (valid_in),
        .operand   (operand),
        .result    (result),
        .flags     (flags),
        .valid_out (valid_out)
    );

    rsqrt_checker monitor (
        .clk       (clk),
        .rst       (rst),
        .result    (result),
        .flags     (flags),
        .valid_out (valid_out),
        .checked   (checked),
        .failed    (failed)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic load_operands();
        int          fd;
        int          n;
        int          tol;
        string       line;
        logic [31:0] op;
        logic [31:0] ex;
        logic [3:0]  fl;
        fd = $fopen("tb/rsqrt_stim.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() == 0 || line[0] == 8'h23) begin
                    continue;
                end
                n = $sscanf(line, "%h %h %d %h", op, ex, tol, fl);
                if (n == 4) begin
                    ops.push_back(op);
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    initial begin
        int gap;
        rst       = 1'b1;
        valid_in  = 1'b0;
        operand   = '0;
        rng_state = 32'hcb249d23;
        load_operands();
        // reset, worst-case gaps of two idle cycles, drain and margin
        limit = 3 + 3 * ops.size() + RSQRT_LATENCY + 20;
        repeat (3) @(posedge clk);
        #2 rst = 1'b0;
        for (int i = 0; i < ops.size(); i++) begin
            @(posedge clk);
            #2;
            valid_in = 1'b1;
            operand  = ops[i];
            rng_state = xorshift(rng_state);
            gap = int'(rng_state % 32'd3);
            repeat (gap) begin
                @(posedge clk);
                #2;
                valid_in = 1'b0;
                operand  = '0;
            end
        end
        @(posedge clk);
        #2 valid_in = 1'b0;
        while (checked < ops.size() && cycles < limit) begin
            @(posedge clk);
        end
        // a few more cycles to catch stray results
        repeat (4) @(posedge clk);
        if (ops.size() == 0) begin
            $display("no test vectors were loaded from the stimulus file");
        end
        if (checked < ops.size()) begin
            $display("timeout after %0d cycles, results were missing: %0d of %0d received",
                     cycles, checked, ops.size());
        end
        $display("summary: %0d tests, %0d checked, %0d passed, %0d failed",
                 ops.size(), checked, checked - failed, failed);
        if (ops.size() > 0 && checked == ops.size() && failed == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
